// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mini_core_tb
FILELIST  ?= mini_core.f
OBJ_DIR   ?= obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    issue_if.execute              iss,
    output logic [DATA_WIDTH-1:0] alu_result_o,
    result_if.execute             res
);
    import core_pkg::*;

    localparam int SHAMT_W = $clog2(DATA_WIDTH);

    // Shift amount is b modulo DATA_WIDTH
    logic [SHAMT_W-1:0] shamt;

    assign shamt = iss.b[SHAMT_W-1:0];

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (iss.op)
            OP_ADD:  alu_result_o = iss.a + iss.b;
            OP_SUB:  alu_result_o = iss.a - iss.b;
            OP_AND:  alu_result_o = iss.a & iss.b;
            OP_OR:   alu_result_o = iss.a | iss.b;
            OP_XOR:  alu_result_o = iss.a ^ iss.b;
            OP_SLL:  alu_result_o = iss.a << shamt;
            OP_SRL:  alu_result_o = iss.a >> shamt;
            // b already holds the extended immediate
            OP_ADDI: alu_result_o = iss.a + iss.b;
            default: alu_result_o = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res.valid     <= 1'b0;
            res.writes_rd <= 1'b0;
            res.illegal   <= 1'b0;
        end else begin
            res.valid     <= iss.valid;
            res.writes_rd <= iss.valid && iss.writes_rd;
            res.illegal   <= iss.valid && iss.illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (iss.valid) begin
            res.rd   <= iss.rd;
            res.data <= alu_result_o;
        end
    end

endmodule

// ==== hdl/core_ifs.sv ====
`timescale 1ns/1ps

//////////////////////////////////////////////////////////////////////
// Decode to execute
//////////////////////////////////////////////////////////////////////

interface issue_if #(
    parameter int DATA_WIDTH = 16
);
    import core_pkg::*;

    logic                  valid;
    opcode_e               op;
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    // Only set for a legal op with rd other than r0
    logic                  writes_rd;
    logic                  illegal;

    modport decode (
        output valid, op, rd, a, b, writes_rd, illegal
    );

    modport execute (
        input valid, op, rd, a, b, writes_rd, illegal
    );
endinterface

//////////////////////////////////////////////////////////////////////
// Execute to commit, also the older bypass source
//////////////////////////////////////////////////////////////////////

interface result_if #(
    parameter int DATA_WIDTH = 16
);
    import core_pkg::*;

    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_WIDTH-1:0] data;
    logic                  writes_rd;
    logic                  illegal;

    modport execute (
        output valid, rd, data, writes_rd, illegal
    );

    modport commit (
        input valid, rd, data, writes_rd, illegal
    );

    modport bypass (
        input rd, data, writes_rd
    );
endinterface

//////////////////////////////////////////////////////////////////////
// Register file read ports, combinational
//////////////////////////////////////////////////////////////////////

interface regfile_rd_if #(
    parameter int DATA_WIDTH = 16
);
    import core_pkg::*;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [DATA_WIDTH-1:0] rs1_data;
    logic [DATA_WIDTH-1:0] rs2_data;

    modport decode (
        output rs1_addr, rs2_addr,
        input  rs1_data, rs2_data
    );

    modport regfile (
        input  rs1_addr, rs2_addr,
        output rs1_data, rs2_data
    );
endinterface

// ==== hdl/core_pkg.sv ====
package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction word layout
    //////////////////////////////////////////////////////////////////////

    localparam int INSTR_W    = 16;
    localparam int OPC_W      = 4;
    localparam int REG_ADDR_W = 3;
    localparam int NUM_REGS   = 8;
    localparam int IMM_W      = 6;

    // Field positions, lsb of each field
    localparam int OPC_LSB = 12;
    localparam int RD_LSB  = 9;
    localparam int RS1_LSB = 6;
    localparam int RS2_LSB = 3;
    // ADDI immediate sits where rs2 and the unused bits are
    localparam int IMM_LSB = 0;

    //////////////////////////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////////////////////////

    // Codes above OP_ADDI are illegal
    typedef enum logic [OPC_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_ADDI = 4'd7
    } opcode_e;

endpackage

// ==== hdl/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         instr_valid_i,
    input  logic [core_pkg::INSTR_W-1:0] instr_i,
    regfile_rd_if.decode                 rf,
    input  logic [DATA_WIDTH-1:0]        alu_result_i,
    result_if.bypass                     fwd,
    issue_if.decode                      iss
);
    import core_pkg::*;

    opcode_e               opc;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [IMM_W-1:0]      imm;
    logic [DATA_WIDTH-1:0] imm_sext;
    logic                  illegal;
    logic                  writes_rd;
    logic [DATA_WIDTH-1:0] op_a;
    logic [DATA_WIDTH-1:0] op_b;

    //////////////////////////////////////////////////////////////////////
    // Field split
    //////////////////////////////////////////////////////////////////////

    assign opc = opcode_e'(instr_i[OPC_LSB +: OPC_W]);
    assign rd  = instr_i[RD_LSB +: REG_ADDR_W];
    assign rs1 = instr_i[RS1_LSB +: REG_ADDR_W];
    assign rs2 = instr_i[RS2_LSB +: REG_ADDR_W];
    assign imm = instr_i[IMM_LSB +: IMM_W];

    assign imm_sext = {{(DATA_WIDTH - IMM_W){imm[IMM_W-1]}}, imm};

    // Opcodes 8 to 15
    assign illegal   = (opc > OP_ADDI);
    // r0 is never a destination
    assign writes_rd = !illegal && (rd != '0);

    // Register file read, rs2 read is unused for ADDI
    assign rf.rs1_addr = rs1;
    assign rf.rs2_addr = rs2;

    //////////////////////////////////////////////////////////////////////
    // Operand bypass
    //////////////////////////////////////////////////////////////////////

    // Youngest producer first: the op now in execute, then the one
    // sitting in the result register, then the register file
    function automatic logic [DATA_WIDTH-1:0] bypass_sel(
        input logic [REG_ADDR_W-1:0] src,
        input logic [DATA_WIDTH-1:0] rf_data
    );
        logic [DATA_WIDTH-1:0] val;
        if (iss.writes_rd && (iss.rd == src)) begin
            val = alu_result_i;
        end else if (fwd.writes_rd && (fwd.rd == src)) begin
            val = fwd.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    always_comb begin
        op_a = bypass_sel(rs1, rf.rs1_data);
        if (opc == OP_ADDI) begin
            op_b = imm_sext;
        end else begin
            op_b = bypass_sel(rs2, rf.rs2_data);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Decode register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            iss.valid     <= 1'b0;
            iss.writes_rd <= 1'b0;
            iss.illegal   <= 1'b0;
        end else begin
            iss.valid     <= instr_valid_i;
            iss.writes_rd <= instr_valid_i && writes_rd;
            iss.illegal   <= instr_valid_i && illegal;
        end
    end

    // Payload only moves with a valid instruction
    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            iss.op <= opc;
            iss.rd <= rd;
            iss.a  <= op_a;
            iss.b  <= op_b;
        end
    end

endmodule

// ==== hdl/mini_core_top.sv ====
`timescale 1ns/1ps

module mini_core_top #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            instr_valid_i,
    input  logic [core_pkg::INSTR_W-1:0]    instr_i,
    output logic                            retire_valid_o,
    output logic                            illegal_o,
    output logic [core_pkg::REG_ADDR_W-1:0] retire_rd_o,
    output logic [DATA_WIDTH-1:0]           retire_data_o
);

    issue_if      #(.DATA_WIDTH(DATA_WIDTH)) iss_bus ();
    result_if     #(.DATA_WIDTH(DATA_WIDTH)) res_bus ();
    regfile_rd_if #(.DATA_WIDTH(DATA_WIDTH)) rf_bus  ();

    // Execute result back to decode for the one-cycle bypass
    logic [DATA_WIDTH-1:0] alu_result;

    //////////////////////////////////////////////////////////////////////
    // Pipeline stages
    //////////////////////////////////////////////////////////////////////

    instr_decode #(
        .DATA_WIDTH    (DATA_WIDTH)
    ) u_decode (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rf            (rf_bus.decode),
        .alu_result_i  (alu_result),
        .fwd           (res_bus.bypass),
        .iss           (iss_bus.decode)
    );

    alu_execute #(
        .DATA_WIDTH    (DATA_WIDTH)
    ) u_execute (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .iss           (iss_bus.execute),
        .alu_result_o  (alu_result),
        .res           (res_bus.execute)
    );

    reg_commit #(
        .DATA_WIDTH     (DATA_WIDTH)
    ) u_commit (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .res            (res_bus.commit),
        .rf             (rf_bus.regfile),
        .retire_valid_o (retire_valid_o),
        .illegal_o      (illegal_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

endmodule

// ==== hdl/reg_commit.sv ====
`timescale 1ns/1ps

module reg_commit #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                            clk,
    input  logic                            arst_n_i,
    result_if.commit                        res,
    regfile_rd_if.regfile                   rf,
    output logic                            retire_valid_o,
    output logic                            illegal_o,
    output logic [core_pkg::REG_ADDR_W-1:0] retire_rd_o,
    output logic [DATA_WIDTH-1:0]           retire_data_o
);
    import core_pkg::*;

    logic [DATA_WIDTH-1:0] regs [NUM_REGS];

    //////////////////////////////////////////////////////////////////////
    // Architectural register file
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (res.valid && res.writes_rd) begin
            regs[res.rd] <= res.data;
        end
    end

    // r0 reads zero whatever the array holds
    assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 : regs[rf.rs1_addr];
    assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 : regs[rf.rs2_addr];

    //////////////////////////////////////////////////////////////////////
    // Retire outputs
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_valid_o <= 1'b0;
            illegal_o      <= 1'b0;
        end else begin
            retire_valid_o <= res.valid && !res.illegal;
            illegal_o      <= res.valid && res.illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (res.valid) begin
            retire_rd_o   <= res.rd;
            retire_data_o <= res.data;
        end
    end

endmodule

// ==== mini_core.f ====
hdl/core_pkg.sv
hdl/core_ifs.sv
hdl/instr_decode.sv
hdl/alu_execute.sv
hdl/reg_commit.sv
hdl/mini_core_top.sv
tests/mini_core_chk.sv
tests/mini_core_tb.sv

// ==== tests/mini_core_chk.sv ====
`timescale 1ns/1ps

module mini_core_chk (
    input logic clk,
    input logic arst_n_i,
    input logic instr_valid_i,
    input logic retire_valid_i,
    input logic illegal_i
);

    // One outcome per instruction
    a_one_outcome: assert property (@(posedge clk) !(retire_valid_i && illegal_i))
        else $error("retire_valid_o and illegal_o high in the same cycle");

    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n_i |-> (!retire_valid_i && !illegal_i))
        else $error("retire outputs active while reset is asserted");

    // Outputs seen at this edge were loaded one edge earlier,
    // two edges after the instruction was sampled
    a_fixed_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        (retire_valid_i || illegal_i) == $past(instr_valid_i, 3))
        else $error("retire pulse does not follow its instruction by two cycles");

endmodule

bind mini_core_top mini_core_chk u_chk (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .instr_valid_i  (instr_valid_i),
    .retire_valid_i (retire_valid_o),
    .illegal_i      (illegal_o)
);

// ==== tests/mini_core_tb.sv ====
`timescale 1ns/1ps

module mini_core_tb;

    localparam int DATA_WIDTH = 16;
    localparam int CLK_PERIOD = 100;
    localparam int N_ALU      = 300;
    localparam int N_CHAIN    = 100;
    localparam int N_R0       = 20;
    localparam int N_ILLEGAL  = 24;
    localparam int N_BURST    = 40;
    localparam int TOTAL_INSTR = 8 + N_ALU + N_CHAIN + 3 * N_R0 + 2 * N_ILLEGAL + 7 + N_BURST;
    // Gaps are at most three idle cycles per instruction
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 4 + 200;

    typedef struct packed {
        logic                  illegal;
        logic [2:0]            rd;
        logic [DATA_WIDTH-1:0] data;
        int                    cycle;
    } retire_t;

    logic                  clk;
    logic                  arst_n_i;
    logic                  instr_valid_i;
    logic [15:0]           instr_i;
    logic                  retire_valid_o;
    logic                  illegal_o;
    logic [2:0]            retire_rd_o;
    logic [DATA_WIDTH-1:0] retire_data_o;

    logic [15:0]           lfsr_state;
    logic [DATA_WIDTH-1:0] model_regs [8];
    retire_t               exp_q [$];
    int                    cycle_cnt;
    int                    sent;
    int                    checks;
    int                    errors;

    mini_core_top #(
        .DATA_WIDTH     (DATA_WIDTH)
    ) dut_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .retire_valid_o (retire_valid_o),
        .illegal_o      (illegal_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // Random source and reference model
    //////////////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] random_legal();
        return {1'b0, 3'(rand_bits(3)), 3'(rand_bits(3)), 3'(rand_bits(3)), 6'(rand_bits(6))};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] model_alu(
        input logic [3:0]            op,
        input logic [DATA_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] b
    );
        int sh;
        sh = int'(b) % DATA_WIDTH;
        case (op)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return a & b;
            4'd3:    return a | b;
            4'd4:    return a ^ b;
            4'd5:    return a << sh;
            4'd6:    return a >> sh;
            4'd7:    return a + b;
            default: return '0;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Driver, monitor and reporting
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic idle_cycles(input int n);
        instr_valid_i = 1'b0;
        repeat (n) begin
            instr_i = 16'(rand_bits(16));
            @(posedge clk);
            #1;
        end
    endtask

    // Model runs in program order and queues the expectation for the monitor
    task automatic send_instr(input logic [15:0] instr);
        retire_t               e;
        logic [3:0]            op;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        op = instr[15:12];
        a  = model_regs[instr[8:6]];
        if (op == 4'd7) begin
            b = {{(DATA_WIDTH - 6){instr[5]}}, instr[5:0]};
        end else begin
            b = model_regs[instr[5:3]];
        end
        e.illegal = op[3];
        e.rd      = instr[11:9];
        e.data    = model_alu(op, a, b);
        // Sampled at the next edge and visible two edges later
        e.cycle   = cycle_cnt + 3;
        if (!e.illegal && e.rd != 3'd0) begin
            model_regs[e.rd] = e.data;
        end
        exp_q.push_back(e);
        sent++;
        instr_valid_i = 1'b1;
        instr_i       = instr;
        @(posedge clk);
        #1;
        instr_valid_i = 1'b0;
        instr_i       = 16'(rand_bits(16));
    endtask

    task automatic check_retire();
        retire_t e;
        if (exp_q.size() == 0) begin
            $display("ERROR: at %0t ns the DUT retired with no instruction outstanding", $time);
            errors++;
        end else begin
            e = exp_q.pop_front();
            checks++;
            if (e.cycle != cycle_cnt) begin
                report_mismatch($sformatf("retire at cycle %0d, expected %0d", cycle_cnt, e.cycle));
            end
            if (e.illegal) begin
                if (!illegal_o || retire_valid_o) begin
                    report_mismatch("illegal opcode did not raise illegal_o alone");
                end
            end else begin
                if (!retire_valid_o || illegal_o) begin
                    report_mismatch("legal instruction did not raise retire_valid_o alone");
                end
                if (retire_rd_o != e.rd) begin
                    report_mismatch($sformatf("rd %0d, expected %0d", retire_rd_o, e.rd));
                end
                if (retire_data_o != e.data) begin
                    report_mismatch($sformatf("data 0x%0h, expected 0x%0h", retire_data_o, e.data));
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (arst_n_i === 1'b1 && (retire_valid_o || illegal_o)) begin
            check_retire();
        end
    end

    task automatic end_test(input string name, input int err_start);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 8) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR: %0d instructions never retired", exp_q.size());
            errors++;
            exp_q.delete();
        end
        $display("%-12s finished with %0d errors", name, errors - err_start);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic run_tests();
        int         err0;
        logic [2:0] prev1;
        logic [2:0] prev2;
        logic [2:0] rd;
        logic [2:0] rs1;
        logic [2:0] rs2;
        // Quiet after reset and then OR reads of an all zero file
        err0 = errors;
        idle_cycles(5);
        for (int i = 0; i < 8; i++) begin
            send_instr({4'd3, 3'(rand_bits(3)), 3'(rand_bits(3)), 3'(rand_bits(3)), 3'b000});
        end
        end_test("reset_state", err0);

        err0 = errors;
        for (int i = 0; i < N_ALU; i++) begin
            send_instr(random_legal());
            idle_cycles(int'(rand_bits(2)));
        end
        end_test("alu_random", err0);

        // Sources taken from the one or two previous destinations
        err0  = errors;
        prev1 = 3'd1;
        prev2 = 3'd2;
        for (int i = 0; i < N_CHAIN; i++) begin
            rd = 3'(rand_bits(3));
            if (rd == 3'd0) begin
                rd = 3'd7;
            end
            rs1 = (rand_bits(1) != 32'd0) ? prev1 : prev2;
            case (2'(rand_bits(2)))
                2'd0:    rs2 = prev1;
                2'd1:    rs2 = prev2;
                default: rs2 = 3'(rand_bits(3));
            endcase
            send_instr({1'b0, 3'(rand_bits(3)), rd, rs1, rs2, 3'(rand_bits(3))});
            prev2 = prev1;
            prev1 = rd;
        end
        end_test("bypass_chain", err0);

        // Write r0 and then read it through both bypass slots
        err0 = errors;
        for (int i = 0; i < N_R0; i++) begin
            send_instr({1'b0, 3'(rand_bits(3)), 3'd0, 3'(rand_bits(3)), 6'(rand_bits(6))});
            send_instr({4'd3, 3'(rand_bits(3)), 3'd0, 3'd0, 3'b000});
            send_instr({4'd0, 3'(rand_bits(3)), 3'd0, 3'(rand_bits(3)), 3'b000});
        end
        end_test("r0_zero", err0);

        err0 = errors;
        for (int i = 0; i < N_ILLEGAL; i++) begin
            rd = 3'(rand_bits(3));
            send_instr({1'b1, 3'(rand_bits(3)), rd, 3'(rand_bits(3)), 6'(rand_bits(6))});
            send_instr({4'd3, rd, rd, 3'd0, 3'b000});
        end
        for (int r = 1; r < 8; r++) begin
            send_instr({4'd3, 3'(r), 3'(r), 3'd0, 3'b000});
        end
        end_test("illegal_op", err0);

        err0 = errors;
        for (int i = 0; i < N_BURST; i++) begin
            send_instr(16'(rand_bits(16)));
        end
        end_test("latency", err0);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        arst_n_i      = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        lfsr_state    = 16'd96;
        cycle_cnt     = 0;
        sent          = 0;
        checks        = 0;
        errors        = 0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        #1;
        arst_n_i = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        run_tests();
        $display("Summary: %0d instructions, %0d checks, %0d errors", sent, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
